//--- all.f
+incdir+design
design/dma_reg_pkg.sv
design/dma_stream_pkg.sv
design/axi_lite_slave.sv
design/dma_regs.sv
design/ring_writer.sv
design/circular_dma.sv
dv/circular_dma_tb.sv

//--- dv/circular_dma_tb.sv
`default_nettype none
`include "dma_params.svh"

module circular_dma_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import dma_reg_pkg::*;
	import dma_stream_pkg::*;

	localparam logic [`DMA_ADDR_W-1:0] addr_ctrl    = 12'h000;
	localparam logic [`DMA_ADDR_W-1:0] addr_irq     = 12'h004;
	localparam logic [`DMA_ADDR_W-1:0] addr_base    = 12'h008;
	localparam logic [`DMA_ADDR_W-1:0] addr_base_hi = 12'h00c;
	localparam logic [`DMA_ADDR_W-1:0] addr_size    = 12'h010;
	localparam logic [`DMA_ADDR_W-1:0] addr_written = 12'h014;
	localparam logic [`DMA_ADDR_W-1:0] addr_msg_end = 12'h018;
	localparam logic [`DMA_ADDR_W-1:0] addr_timeout = 12'h01c;

	logic                     clk;
	logic                     reset;
	logic [`DMA_ADDR_W-1:0]   s_axi_awaddr;
	logic                     s_axi_awvalid;
	logic                     s_axi_awready;
	logic [`DMA_DATA_W-1:0]   s_axi_wdata;
	logic [`DMA_DATA_W/8-1:0] s_axi_wstrb;
	logic                     s_axi_wvalid;
	logic                     s_axi_wready;
	logic [1:0]               s_axi_bresp;
	logic                     s_axi_bvalid;
	logic                     s_axi_bready;
	logic [`DMA_ADDR_W-1:0]   s_axi_araddr;
	logic                     s_axi_arvalid;
	logic                     s_axi_arready;
	logic [`DMA_DATA_W-1:0]   s_axi_rdata;
	logic [1:0]               s_axi_rresp;
	logic                     s_axi_rvalid;
	logic                     s_axi_rready;
	logic                     s_valid;
	logic                     s_ready;
	stream_beat_t             s_beat;
	logic                     m_valid;
	logic                     m_ready;
	mem_write_t               m_write;
	logic                     irq_out;

	integer      seed = 32'h072b_fd08;
	integer      mem_seed = 32'h072b_fd08;
	int          checks = 0;
	int          mismatches = 0;
	int          failures = 0;
	int          write_idx = 0;
	logic [31:0] beat_seq = 32'h0000_1000;
	logic [31:0] cfg_base = '0;
	logic [31:0] cfg_size = '0;
	logic [63:0] exp_data[$];
	mem_write_t  write_log[$];

	circular_dma dut0 (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] ref_merge(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				merged[8*b +: 8] = data[8*b +: 8];
		end
		return merged;
	endfunction

	// Address of the n-th write since reset
	function automatic logic [31:0] ref_next_addr(input logic [31:0] base,
		input logic [31:0] size, input int index);
		logic [31:0] span;
		span = 32'(index) * 8;
		if (size == 0)
			return base;
		return base + (span % size);
	endfunction

	function automatic axi_resp_e ref_resp(input logic [`DMA_ADDR_W-1:0] addr);
		return (addr > `DMA_REG_SPAN) ? resp_slverr : resp_okay;
	endfunction

	task automatic check(input logic [63:0] expected, input logic [63:0] actual,
		input string name);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic print_counts();
		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
	endtask

	task automatic axi_write(input logic [`DMA_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		@(posedge clk);
		s_axi_awaddr <= addr;
		s_axi_awvalid <= 1'b1;
		s_axi_wdata <= data;
		s_axi_wstrb <= strb;
		s_axi_wvalid <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!s_axi_awready && n < 100);
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid <= 1'b0;
		if (!s_axi_awready) begin
			failures++;
			$display("ERROR at %0t: write to address %h was never accepted", $time, addr);
		end else begin
			check(1'b1, s_axi_wready, "s_axi_wready");
			s_axi_bready <= 1'b1;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!s_axi_bvalid && n < 100);
			s_axi_bready <= 1'b0;
			if (!s_axi_bvalid) begin
				failures++;
				$display("ERROR at %0t: no write response for address %h", $time, addr);
			end else begin
				check(ref_resp(addr), s_axi_bresp, "bresp");
			end
		end
	endtask

	task automatic axi_read(input logic [`DMA_ADDR_W-1:0] addr, output logic [31:0] data);
		int n;
		data = 'x;
		@(posedge clk);
		s_axi_araddr <= addr;
		s_axi_arvalid <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!s_axi_arready && n < 100);
		s_axi_arvalid <= 1'b0;
		if (!s_axi_arready) begin
			failures++;
			$display("ERROR at %0t: read of address %h was never accepted", $time, addr);
		end else begin
			s_axi_rready <= 1'b1;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!s_axi_rvalid && n < 100);
			s_axi_rready <= 1'b0;
			if (!s_axi_rvalid) begin
				failures++;
				$display("ERROR at %0t: no read data for address %h", $time, addr);
			end else begin
				data = s_axi_rdata;
				check(ref_resp(addr), s_axi_rresp, "rresp");
			end
		end
	endtask

	task automatic read_check(input logic [`DMA_ADDR_W-1:0] addr, input logic [31:0] want,
		input string name);
		logic [31:0] data;
		axi_read(addr, data);
		check(want, data, name);
	endtask

	// last_at counts from 1 and zero sends no last
	task automatic send_beats(input int count, input int last_at);
		stream_beat_t beat;
		int n;
		@(posedge clk);
		for (int i = 1; i <= count; i++) begin
			beat.data = {beat_seq, ~beat_seq};
			beat.last = (i == last_at);
			beat_seq = beat_seq + 1;
			s_valid <= 1'b1;
			s_beat <= beat;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!s_ready && n < 500);
			if (s_ready) begin
				exp_data.push_back(beat.data);
			end else begin
				failures++;
				$display("ERROR at %0t: stream beat %0d was never accepted", $time, i);
			end
		end
		s_valid <= 1'b0;
	endtask

	task automatic wait_writes(input int target);
		int n;
		n = 0;
		while (write_idx < target && n < 2000) begin
			@(posedge clk);
			n++;
		end
		if (write_idx < target) begin
			failures++;
			$display("ERROR at %0t: only %0d of %0d memory writes completed", $time,
				write_idx, target);
		end
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq_out !== level && n < 50) begin
			@(posedge clk);
			n++;
		end
		check(level, irq_out, "irq_out");
	endtask

	// Memory model checking each completed write in order
	always @(posedge clk) begin
		if (m_valid && m_ready) begin
			write_log.push_back(m_write);
			if (exp_data.size() == 0) begin
				failures++;
				$display("ERROR at %0t: memory write with no stream beat pending", $time);
			end else begin
				check(ref_next_addr(cfg_base, cfg_size, write_idx), m_write.addr, "m_write.addr");
				check(exp_data.pop_front(), m_write.data, "m_write.data");
			end
			write_idx <= write_idx + 1;
		end
		m_ready <= ($random(mem_seed) & 3) != 0;
	end

	initial begin : watchdog
		#200_000;
		$display("ERROR: simulation still running after 200 us");
		print_counts();
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin : main
		logic [31:0]            rdata;
		logic [31:0]            old;
		logic [31:0]            data;
		logic [31:0]            keep;
		logic [31:0]            want;
		logic [31:0]            shadow [4];
		logic [3:0]             strb;
		logic [`DMA_ADDR_W-1:0] addr;

		clk = 1'b0;
		reset = 1'b1;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		s_valid = 1'b0;
		s_beat = '0;
		m_ready = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check(0, irq_out, "irq_out after reset");
		check(0, m_valid, "m_valid after reset");
		check(0, s_ready, "s_ready after reset");

		read_check(addr_ctrl, 0, "ctrl reset");
		read_check(addr_irq, 0, "irq reset");
		read_check(addr_base, 0, "base reset");
		read_check(addr_base_hi, 0, "base_hi reset");
		read_check(addr_size, 0, "size reset");
		read_check(addr_timeout, `DMA_TIMEOUT_RESET, "timeout reset");
		read_check(addr_written, 0, "bytes_written reset");
		read_check(addr_msg_end, 0, "last_msg_end reset");

		// Random strobe writes
		shadow[0] = '0;
		shadow[1] = '0;
		shadow[2] = `DMA_TIMEOUT_RESET;
		shadow[3] = '0;
		for (int i = 0; i < 12; i++) begin
			case (i % 4)
				0: begin
					addr = addr_base;
					keep = 32'hffff_fff8;
				end
				1: begin
					addr = addr_size;
					keep = 32'hffff_fff8;
				end
				2: begin
					addr = addr_timeout;
					keep = 32'hffff_ffff;
				end
				default: begin
					addr = addr_irq;
					keep = 32'h0003_0000;
				end
			endcase
			old = shadow[i % 4];
			data = $random(seed);
			strb = $random(seed);
			axi_write(addr, data, strb);
			want = ref_merge(old, data, strb) & keep;
			shadow[i % 4] = want;
			read_check(addr, want, $sformatf("reg %h", addr));
		end

		// Out of range accesses leave ctrl untouched
		axi_write(12'h020, 32'hffff_ffff, 4'hf);
		axi_write(12'hffc, 32'hffff_ffff, 4'hf);
		axi_read(12'h020, rdata);
		axi_read(12'h400, rdata);
		read_check(addr_ctrl, 0, "ctrl after bad write");

		// Ring wrap
		cfg_base = 32'h0000_1000;
		cfg_size = 32'd64;
		axi_write(addr_base, cfg_base, 4'hf);
		axi_write(addr_size, cfg_size, 4'hf);
		axi_write(addr_timeout, 32'd1_000_000, 4'hf);
		axi_write(addr_irq, 32'h0000_0003, 4'hf);
		axi_write(addr_ctrl, 32'h1, 4'hf);
		send_beats(20, 20);
		wait_writes(20);
		read_check(addr_written, 160, "bytes_written");
		axi_read(addr_ctrl, rdata);
		check(1, rdata[16], "running flag");
		check(1, rdata[18], "wrapped flag");
		check(20, write_log.size(), "logged writes");
		check(0, exp_data.size(), "beats left unwritten");

		// Message interrupt
		axi_write(addr_irq, 32'h0000_0003, 4'hf);
		send_beats(5, 5);
		wait_writes(25);
		read_check(addr_irq, 32'h0000_0001, "irq raw");
		read_check(addr_msg_end, ref_next_addr(cfg_base, cfg_size, 25) - cfg_base,
			"last_msg_end");
		check(0, irq_out, "irq_out masked");
		axi_write(addr_irq, 32'h0001_0000, 4'hf);
		wait_irq(1'b1);
		axi_write(addr_irq, 32'h0001_0001, 4'hf);
		wait_irq(1'b0);
		read_check(addr_irq, 32'h0001_0000, "irq after clear");

		// Timeout interrupt on an open message
		axi_write(addr_timeout, 32'd50, 4'hf);
		send_beats(2, 0);
		wait_writes(27);
		repeat (200) @(posedge clk);
		read_check(addr_irq, 32'h0001_0002, "irq timeout raw");
		check(0, irq_out, "irq_out timeout masked");
		axi_write(addr_irq, 32'h0002_0000, 4'hf);
		wait_irq(1'b1);

		// Soft reset
		axi_write(addr_ctrl, 32'h3, 4'hf);
		read_check(addr_ctrl, 32'h2, "ctrl in srst");
		read_check(addr_irq, 0, "irq in srst");
		read_check(addr_base, 0, "base in srst");
		read_check(addr_size, 0, "size in srst");
		read_check(addr_timeout, `DMA_TIMEOUT_RESET, "timeout in srst");
		read_check(addr_written, 0, "bytes_written in srst");
		read_check(addr_msg_end, 0, "last_msg_end in srst");
		check(0, irq_out, "irq_out in srst");
		axi_write(addr_ctrl, 32'h0, 4'hf);
		write_idx <= 0;
		cfg_base = 32'h0000_2040;
		axi_write(addr_base, cfg_base, 4'hf);
		axi_write(addr_size, cfg_size, 4'hf);
		axi_write(addr_ctrl, 32'h1, 4'hf);
		send_beats(1, 1);
		wait_writes(1);
		read_check(addr_written, 8, "bytes_written after srst");
		check(0, exp_data.size(), "beats left unwritten");

		print_counts();
		if (mismatches == 0 && failures == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/circular_dma.sv
`default_nettype none
`include "dma_params.svh"

module circular_dma (
	input  logic                         clk,
	input  logic                         reset,

	input  logic [`DMA_ADDR_W-1:0]       s_axi_awaddr,
	input  logic                         s_axi_awvalid,
	output logic                         s_axi_awready,
	input  logic [`DMA_DATA_W-1:0]       s_axi_wdata,
	input  logic [`DMA_DATA_W/8-1:0]     s_axi_wstrb,
	input  logic                         s_axi_wvalid,
	output logic                         s_axi_wready,
	output logic [1:0]                   s_axi_bresp,
	output logic                         s_axi_bvalid,
	input  logic                         s_axi_bready,
	input  logic [`DMA_ADDR_W-1:0]       s_axi_araddr,
	input  logic                         s_axi_arvalid,
	output logic                         s_axi_arready,
	output logic [`DMA_DATA_W-1:0]       s_axi_rdata,
	output logic [1:0]                   s_axi_rresp,
	output logic                         s_axi_rvalid,
	input  logic                         s_axi_rready,

	input  logic                         s_valid,
	output logic                         s_ready,
	input  dma_stream_pkg::stream_beat_t s_beat,

	output logic                         m_valid,
	input  logic                         m_ready,
	output dma_stream_pkg::mem_write_t   m_write,

	output logic                         irq_out
);
	import dma_reg_pkg::*;
	import dma_stream_pkg::*;

	// Register request path
	logic                     read_req;
	logic [`DMA_ADDR_W-1:0]   read_addr;
	logic                     read_ok;
	logic [`DMA_DATA_W-1:0]   read_value;
	logic                     write_req;
	logic [`DMA_ADDR_W-1:0]   write_addr;
	logic [`DMA_DATA_W-1:0]   write_data;
	logic [`DMA_DATA_W/8-1:0] write_strb;
	logic                     write_ok;

	dma_ctrl_t                ctrl;
	dma_status_t              status;

	axi_lite_slave u_slave (.*);

	dma_regs u_regs (.*);

	ring_writer u_writer (.*);

endmodule

`default_nettype wire

//--- design/ring_writer.sv
`default_nettype none
`include "dma_params.svh"

module ring_writer (
	input  logic                         clk,
	input  logic                         reset,
	input  dma_reg_pkg::dma_ctrl_t       ctrl,
	output dma_stream_pkg::dma_status_t  status,

	input  logic                         s_valid,
	output logic                         s_ready,
	input  dma_stream_pkg::stream_beat_t s_beat,

	output logic                         m_valid,
	input  logic                         m_ready,
	output dma_stream_pkg::mem_write_t   m_write
);
	import dma_stream_pkg::*;

	writer_state_e          state;
	writer_state_e          state_next;
	logic                   wr_reset;
	logic                   s_fire;
	logic                   m_fire;
	logic                   held_last;
	logic                   at_end;
	logic                   in_msg;
	logic                   wrapped;
	logic [1:0]             irq;
	logic [1:0]             irq_set;
	logic [`DMA_DATA_W-1:0] offset;
	logic [`DMA_DATA_W-1:0] offset_step;
	logic [`DMA_DATA_W-1:0] offset_next;
	logic [`DMA_DATA_W-1:0] bytes_written;
	logic [`DMA_DATA_W-1:0] last_msg_end;
	logic [`DMA_DATA_W-1:0] idle_cnt;

	assign wr_reset = reset || ctrl.srst;

	// One holding slot, refilled in the cycle it drains
	assign s_ready = ctrl.enable && (!m_valid || m_ready);
	assign s_fire  = s_valid && s_ready;
	assign m_fire  = m_valid && m_ready;

	assign offset_step = offset + `DMA_DATA_W'(`DMA_STREAM_W / 8);
	assign at_end      = offset_step == ctrl.mem_size;
	assign offset_next = !m_fire ? offset : (at_end ? '0 : offset_step);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: if (ctrl.enable) state_next = st_run;
			st_run, st_stall: begin
				if (m_valid && !m_ready) state_next = st_stall;
				else if (!ctrl.enable) state_next = st_idle;
				else state_next = st_run;
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wr_reset) begin
			state   <= st_idle;
			m_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (s_fire) m_valid <= 1'b1;
			else if (m_ready) m_valid <= 1'b0;
		end
	end

	// New beat lands after any write completing this cycle
	always_ff @(posedge clk) begin
		if (s_fire) begin
			m_write.addr <= ctrl.mem_base + offset_next;
			m_write.data <= s_beat.data;
			held_last    <= s_beat.last;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_reset) begin
			offset        <= '0;
			bytes_written <= '0;
			last_msg_end  <= '0;
			wrapped       <= 1'b0;
		end else if (m_fire) begin
			offset        <= offset_next;
			bytes_written <= bytes_written + `DMA_DATA_W'(`DMA_STREAM_W / 8);
			if (at_end) wrapped <= 1'b1;
			if (held_last) last_msg_end <= offset_next;
		end
	end

	assign irq_set[0] = m_fire && held_last;
	assign irq_set[1] = in_msg && !s_fire && idle_cnt == ctrl.timeout;

	always_ff @(posedge clk) begin
		if (wr_reset) begin
			in_msg   <= 1'b0;
			idle_cnt <= '0;
			irq      <= 2'b00;
		end else begin
			if (s_fire) in_msg <= !s_beat.last;
			// Idle time only counts inside an open message
			if (s_fire || !in_msg) idle_cnt <= '0;
			else idle_cnt <= idle_cnt + 1'b1;
			irq <= (irq & ~ctrl.clear_irq) | irq_set;
		end
	end

	always_comb begin
		status.flags         = {state == st_stall, wrapped, in_msg, state != st_idle};
		status.irq           = irq;
		status.bytes_written = bytes_written;
		status.last_msg_end  = last_msg_end;
	end

	a_write_hold: assert property (@(posedge clk) disable iff (wr_reset)
		m_valid && !m_ready |=> m_valid && $stable(m_write))
		else $error("memory write changed before m_ready");

	a_addr_range: assert property (@(posedge clk) disable iff (wr_reset)
		m_valid && ctrl.mem_size != '0 |->
		{1'b0, m_write.addr} < {1'b0, ctrl.mem_base} + {1'b0, ctrl.mem_size})
		else $error("write address outside the ring buffer");

endmodule

`default_nettype wire

//--- design/dma_regs.sv
`default_nettype none
`include "dma_params.svh"

module dma_regs (
	input  logic                        clk,
	input  logic                        reset,

	input  logic                        read_req,
	input  logic [`DMA_ADDR_W-1:0]      read_addr,
	output logic                        read_ok,
	output logic [`DMA_DATA_W-1:0]      read_value,

	input  logic                        write_req,
	input  logic [`DMA_ADDR_W-1:0]      write_addr,
	input  logic [`DMA_DATA_W-1:0]      write_data,
	input  logic [`DMA_DATA_W/8-1:0]    write_strb,
	output logic                        write_ok,

	output dma_reg_pkg::dma_ctrl_t      ctrl,
	input  dma_stream_pkg::dma_status_t status,
	output logic                        irq_out
);
	import dma_reg_pkg::*;

	logic                   enable;
	logic                   srst;
	logic [1:0]             enable_irq;
	logic [1:0]             clear_irq;
	logic [`DMA_DATA_W-1:0] mem_base;
	logic [`DMA_DATA_W-1:0] mem_size;
	logic [`DMA_DATA_W-1:0] timeout;

	logic [`DMA_DATA_W-1:0] wmask;
	logic [`DMA_DATA_W-1:0] wr_old;
	logic [`DMA_DATA_W-1:0] wr_merged;
	reg_index_e             wr_index;
	reg_index_e             rd_index;

	assign write_ok = write_req && (write_addr <= `DMA_ADDR_W'(`DMA_REG_SPAN));
	assign read_ok  = read_req && (read_addr <= `DMA_ADDR_W'(`DMA_REG_SPAN));

	assign wr_index = reg_index_e'(write_addr[4:2]);
	assign rd_index = reg_index_e'(read_addr[4:2]);

	// Byte strobes to bit mask and merge with the addressed register
	always_comb begin
		for (int i = 0; i < `DMA_DATA_W; i++) begin
			wmask[i] = write_strb[i/8];
		end

		case (wr_index)
			reg_ctrl:    wr_old = {30'd0, srst, enable};
			reg_irq:     wr_old = {14'd0, enable_irq, 16'd0};
			reg_base:    wr_old = mem_base;
			reg_size:    wr_old = mem_size;
			reg_timeout: wr_old = timeout;
			default:     wr_old = '0;
		endcase

		wr_merged = (write_data & wmask) | (wr_old & ~wmask);
	end

	always_ff @(posedge clk) begin
		if (reset || srst) begin
			enable     <= 1'b0;
			clear_irq  <= 2'b00;
			enable_irq <= 2'b00;
			mem_base   <= '0;
			mem_size   <= '0;
			timeout    <= `DMA_DATA_W'(`DMA_TIMEOUT_RESET);
		end else begin
			clear_irq <= 2'b00;
			if (write_ok) begin
				case (wr_index)
					reg_ctrl: enable <= wr_merged[0];
					reg_irq: begin
						clear_irq  <= write_data[1:0] & wmask[1:0];
						enable_irq <= wr_merged[17:16];
					end
					reg_base: mem_base <= {wr_merged[`DMA_DATA_W-1:`DMA_BEAT_BYTES_LOG2],
						{`DMA_BEAT_BYTES_LOG2{1'b0}}};
					reg_size: mem_size <= {wr_merged[`DMA_DATA_W-1:`DMA_BEAT_BYTES_LOG2],
						{`DMA_BEAT_BYTES_LOG2{1'b0}}};
					reg_timeout: timeout <= wr_merged;
					default: ;
				endcase
			end
		end
	end

	// Soft reset bit stays writable while it holds the rest in reset
	always_ff @(posedge clk) begin
		if (reset) begin
			srst <= 1'b0;
		end else if (write_ok && wr_index == reg_ctrl) begin
			srst <= wr_merged[1];
		end
	end

	always_comb begin
		read_value = '0;
		if (read_ok) begin
			case (rd_index)
				reg_ctrl:    read_value = {12'd0, status.flags, 14'd0, srst, enable};
				reg_irq:     read_value = {14'd0, enable_irq, 14'd0, status.irq};
				reg_base:    read_value = mem_base;
				reg_base_hi: read_value = '0;
				reg_size:    read_value = mem_size;
				reg_written: read_value = status.bytes_written;
				reg_msg_end: read_value = status.last_msg_end;
				reg_timeout: read_value = timeout;
				default:     read_value = '0;
			endcase
		end
	end

	always_comb begin
		ctrl.enable    = enable;
		ctrl.srst      = srst;
		ctrl.clear_irq = clear_irq;
		ctrl.mem_base  = mem_base;
		ctrl.mem_size  = mem_size;
		ctrl.timeout   = timeout;
	end

	assign irq_out = |(status.irq & enable_irq);

	a_no_clear_in_reset: assert property (@(posedge clk) disable iff (reset)
		srst |-> clear_irq == 2'b00)
		else $error("clear_irq pulsed during soft reset");

endmodule

`default_nettype wire

//--- design/axi_lite_slave.sv
`default_nettype none
`include "dma_params.svh"

module axi_lite_slave (
	input  logic                     clk,
	input  logic                     reset,

	input  logic [`DMA_ADDR_W-1:0]   s_axi_awaddr,
	input  logic                     s_axi_awvalid,
	output logic                     s_axi_awready,

	input  logic [`DMA_DATA_W-1:0]   s_axi_wdata,
	input  logic [`DMA_DATA_W/8-1:0] s_axi_wstrb,
	input  logic                     s_axi_wvalid,
	output logic                     s_axi_wready,

	output logic [1:0]               s_axi_bresp,
	output logic                     s_axi_bvalid,
	input  logic                     s_axi_bready,

	input  logic [`DMA_ADDR_W-1:0]   s_axi_araddr,
	input  logic                     s_axi_arvalid,
	output logic                     s_axi_arready,

	output logic [`DMA_DATA_W-1:0]   s_axi_rdata,
	output logic [1:0]               s_axi_rresp,
	output logic                     s_axi_rvalid,
	input  logic                     s_axi_rready,

	output logic                     read_req,
	output logic [`DMA_ADDR_W-1:0]   read_addr,
	input  logic                     read_ok,
	input  logic [`DMA_DATA_W-1:0]   read_value,

	output logic                     write_req,
	output logic [`DMA_ADDR_W-1:0]   write_addr,
	output logic [`DMA_DATA_W-1:0]   write_data,
	output logic [`DMA_DATA_W/8-1:0] write_strb,
	input  logic                     write_ok
);
	import dma_reg_pkg::*;

	logic      accept_w;
	logic      accept_r;
	axi_resp_e bresp_q;
	axi_resp_e rresp_q;

	// Address and data together, and only once the last response is gone
	assign accept_w = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
	assign accept_r = s_axi_arvalid && !s_axi_rvalid && !s_axi_arready;

	always_ff @(posedge clk) begin
		if (reset) begin
			s_axi_awready <= 1'b0;
			s_axi_arready <= 1'b0;
		end else begin
			s_axi_awready <= accept_w;
			s_axi_arready <= accept_r;
		end
	end

	assign s_axi_wready = s_axi_awready;

	// Channels are stable during the ready pulse
	assign write_req  = s_axi_awready;
	assign write_addr = s_axi_awaddr;
	assign write_data = s_axi_wdata;
	assign write_strb = s_axi_wstrb;

	assign read_req  = s_axi_arready;
	assign read_addr = s_axi_araddr;

	always_ff @(posedge clk) begin
		if (reset) begin
			s_axi_bvalid <= 1'b0;
		end else if (write_req) begin
			s_axi_bvalid <= 1'b1;
		end else if (s_axi_bready) begin
			s_axi_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (write_req) begin
			bresp_q <= write_ok ? resp_okay : resp_slverr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s_axi_rvalid <= 1'b0;
		end else if (read_req) begin
			s_axi_rvalid <= 1'b1;
		end else if (s_axi_rready) begin
			s_axi_rvalid <= 1'b0;
		end
	end

	// Read data captured with the request
	always_ff @(posedge clk) begin
		if (read_req) begin
			s_axi_rdata <= read_value;
			rresp_q     <= read_ok ? resp_okay : resp_slverr;
		end
	end

	assign s_axi_bresp = bresp_q;
	assign s_axi_rresp = rresp_q;

	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
		else $error("write response changed before bready");

	a_rdata_stable: assert property (@(posedge clk) disable iff (reset)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
		else $error("rdata changed while waiting on rready");

endmodule

`default_nettype wire

//--- design/dma_stream_pkg.sv
`default_nettype none
`include "dma_params.svh"

package dma_stream_pkg;

	typedef struct packed {
		logic [`DMA_STREAM_W-1:0] data;
		logic                     last;
	} stream_beat_t;

	typedef struct packed {
		logic [`DMA_DATA_W-1:0]   addr;
		logic [`DMA_STREAM_W-1:0] data;
	} mem_write_t;

	// Flags are running, in message, wrapped, stalled from bit 0 up
	typedef struct packed {
		logic [3:0]             flags;
		logic [1:0]             irq;
		logic [`DMA_DATA_W-1:0] bytes_written;
		logic [`DMA_DATA_W-1:0] last_msg_end;
	} dma_status_t;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_stall
	} writer_state_e;

endpackage

`default_nettype wire

//--- design/dma_reg_pkg.sv
`default_nettype none
`include "dma_params.svh"

package dma_reg_pkg;

	// Word index inside the register window
	typedef enum logic [2:0] {
		reg_ctrl    = 3'd0,
		reg_irq     = 3'd1,
		reg_base    = 3'd2,
		reg_base_hi = 3'd3,
		reg_size    = 3'd4,
		reg_written = 3'd5,
		reg_msg_end = 3'd6,
		reg_timeout = 3'd7
	} reg_index_e;

	typedef enum logic [1:0] {
		resp_okay   = 2'd0,
		resp_slverr = 2'd2
	} axi_resp_e;

	// Register outputs towards the ring writer
	typedef struct packed {
		logic                   enable;
		logic                   srst;
		logic [1:0]             clear_irq;
		logic [`DMA_DATA_W-1:0] mem_base;
		logic [`DMA_DATA_W-1:0] mem_size;
		logic [`DMA_DATA_W-1:0] timeout;
	} dma_ctrl_t;

endpackage

`default_nettype wire

//--- design/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Register bus
`define DMA_ADDR_W 12
`define DMA_DATA_W 32

// Stream and memory data path
`define DMA_STREAM_W 64

// Base and size are beat aligned
`define DMA_BEAT_BYTES_LOG2 3

// Last byte address of the register window
`define DMA_REG_SPAN 31

// About one second at 125 MHz
`define DMA_TIMEOUT_RESET 125000000

`endif
